/* files.f */
logic/matmul_pkg.sv
logic/matrix_ram.sv
logic/dot_product_mac.sv
logic/matmul_sequencer.sv
logic/matmul_top.sv
verif/matmul_tb.sv

/* verif/matmul_tb.sv */
`timescale 1ns/1ps

module matmul_tb;

    typedef enum logic [1:0] {
        FILL_INC,
        FILL_RAND,
        FILL_EXTREME,
        FILL_IDENT
    } fill_mode_t;

    typedef struct packed {
        matmul_pkg::dim_t m;
        matmul_pkg::dim_t n;
        matmul_pkg::dim_t k;
        fill_mode_t       mode;
        logic             extra;   // stray start and loads mid-run
    } case_row_t;

    case_row_t case_table [10] = '{
        '{5'd1,  5'd1,  5'd1,  FILL_INC,     1'b0},
        '{5'd2,  5'd3,  5'd4,  FILL_IDENT,   1'b0},
        '{5'd2,  5'd3,  5'd4,  FILL_INC,     1'b1},
        '{5'd31, 5'd31, 5'd31, FILL_RAND,    1'b1},
        '{5'd3,  5'd7,  5'd5,  FILL_RAND,    1'b0},
        '{5'd7,  5'd2,  5'd9,  FILL_RAND,    1'b1},
        '{5'd5,  5'd5,  5'd5,  FILL_EXTREME, 1'b0},
        '{5'd1,  5'd31, 5'd2,  FILL_RAND,    1'b0},
        '{5'd31, 5'd1,  5'd31, FILL_RAND,    1'b1},
        '{5'd4,  5'd4,  5'd4,  FILL_EXTREME, 1'b1}
    };

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  start;
    matmul_pkg::dim_t      m;
    matmul_pkg::dim_t      n;
    matmul_pkg::dim_t      k;
    logic                  load_we;
    matmul_pkg::load_sel_t load_sel;
    matmul_pkg::addr_t     load_addr;
    matmul_pkg::word_t     load_data;
    matmul_pkg::addr_t     rd_addr;
    matmul_pkg::word_t     rd_data;
    logic                  busy;
    logic                  done;

    // software copies of the operands and the expected product
    matmul_pkg::word_t in_mat  [matmul_pkg::MEM_DEPTH];
    matmul_pkg::word_t wt_mat  [matmul_pkg::MEM_DEPTH];
    matmul_pkg::word_t exp_res [matmul_pkg::MEM_DEPTH];

    logic [31:0] lcg_state = 32'hdf296e6d;

    matmul_top dut0 (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .m         (m),
        .n         (n),
        .k         (k),
        .load_we   (load_we),
        .load_sel  (load_sel),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .busy      (busy),
        .done      (done)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic matmul_pkg::word_t pick_value(fill_mode_t mode, int idx,
                                                     logic is_weight, int row, int col);
        logic [31:0] r;
        r = lcg_next();
        case (mode)
            FILL_INC:     return is_weight ? (idx % 7) - 3 : idx + 1;
            FILL_RAND:    return r;
            FILL_EXTREME: begin
                case (r[31:30])
                    2'd0:    return 32'h8000_0000;   // -2^31
                    2'd1:    return 32'h7fff_ffff;
                    2'd2:    return 32'hffff_ffff;
                    default: return 32'h8000_0001;
                endcase
            end
            default: begin
                if (is_weight) return (row == col) ? 1 : 0;
                return $signed(r) >>> 20;
            end
        endcase
    endfunction

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERR time %0t ns %s expected %h actual %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    // called on a falling edge, returns on the next one
    task automatic write_word(matmul_pkg::load_sel_t sel, int addr, matmul_pkg::word_t data);
        load_we   = 1'b1;
        load_sel  = sel;
        load_addr = addr;
        load_data = data;
        @(negedge clk);
        load_we = 1'b0;
    endtask

    task automatic fill_operands(case_row_t row);
        for (int i = 0; i < row.m; i++) begin
            for (int p = 0; p < row.k; p++) begin
                in_mat[i*row.k+p] = pick_value(row.mode, i*row.k+p, 1'b0, i, p);
                write_word(matmul_pkg::LOAD_INPUT, i*row.k+p, in_mat[i*row.k+p]);
            end
        end
        for (int p = 0; p < row.k; p++) begin
            for (int j = 0; j < row.n; j++) begin
                wt_mat[p*row.n+j] = pick_value(row.mode, p*row.n+j, 1'b1, p, j);
                write_word(matmul_pkg::LOAD_WEIGHT, p*row.n+j, wt_mat[p*row.n+j]);
            end
        end
    endtask

    // 32-bit wrapping dot products, row-major result
    task automatic compute_expected(int mm, int nn, int kk);
        matmul_pkg::word_t acc;
        for (int i = 0; i < mm; i++) begin
            for (int j = 0; j < nn; j++) begin
                acc = 0;
                for (int p = 0; p < kk; p++) begin
                    acc = acc + in_mat[i*kk+p] * wt_mat[p*nn+j];
                end
                exp_res[i*nn+j] = acc;
            end
        end
    endtask

    task automatic run_and_time(int mm, int nn, int kk, logic extra);
        int cyc;
        int total;
        total = mm * nn * kk;
        check_value("busy", 0, busy);
        m     = mm;
        n     = nn;
        k     = kk;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        cyc   = 1;
        while (done !== 1'b1 && cyc <= total + 20) begin
            check_value("busy", 1, busy);
            if (extra && cyc == 2) begin
                start     = 1'b1;          // stray start, other dims
                m         = 5'd7;
                n         = 5'd9;
                k         = 5'd3;
                load_we   = 1'b1;
                load_sel  = matmul_pkg::LOAD_INPUT;
                load_addr = '0;
                load_data = ~in_mat[0];
            end else if (extra && cyc == 3) begin
                start     = 1'b0;
                m         = mm;
                n         = nn;
                k         = kk;
                load_sel  = matmul_pkg::LOAD_WEIGHT;
                load_data = ~wt_mat[0];
            end else if (extra && cyc == 4) begin
                load_we = 1'b0;
            end
            @(negedge clk);
            cyc++;
        end
        if (done !== 1'b1) begin
            $display("timeout: no done within %0d cycles of start", total + 20);
            abort_run();
        end
        check_value("done cycle", total + 4, cyc);
        check_value("busy", 1, busy);
        @(negedge clk);
        check_value("busy", 0, busy);
        check_value("done", 0, done);
    endtask

    task automatic read_results(int mm, int nn);
        for (int a = 0; a < mm * nn; a++) begin
            rd_addr = a;
            @(negedge clk);
            check_value($sformatf("rd_data[%0d]", a), exp_res[a], rd_data);
        end
    endtask

    // start with one zero dimension, engine has to stay idle
    task automatic ignored_start(int mm, int nn, int kk, int zero_pos);
        m     = (zero_pos == 0) ? 0 : mm;
        n     = (zero_pos == 1) ? 0 : nn;
        k     = (zero_pos == 2) ? 0 : kk;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        for (int c = 0; c < 40; c++) begin
            check_value("busy", 0, busy);
            check_value("done", 0, done);
            @(negedge clk);
        end
    endtask

    initial begin
        case_row_t row;
        reset     = 1'b1;
        start     = 1'b0;
        m         = '0;
        n         = '0;
        k         = '0;
        load_we   = 1'b0;
        load_sel  = matmul_pkg::LOAD_INPUT;
        load_addr = '0;
        load_data = '0;
        rd_addr   = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        check_value("busy", 0, busy);
        check_value("done", 0, done);

        for (int r = 0; r < 10; r++) begin
            row = case_table[r];
            fill_operands(row);
            compute_expected(row.m, row.n, row.k);
            run_and_time(row.m, row.n, row.k, row.extra);
            read_results(row.m, row.n);
            if (row.extra) begin
                for (int z = 0; z < 3; z++) begin
                    ignored_start(row.m, row.n, row.k, z);
                end
                read_results(row.m, row.n);
                // a rerun only matches if the blocked loads missed the operands
                run_and_time(row.m, row.n, row.k, 1'b0);
                read_results(row.m, row.n);
            end
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* logic/matmul_top.sv */
`timescale 1ns/1ps

module matmul_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  matmul_pkg::dim_t      m,
    input  matmul_pkg::dim_t      n,
    input  matmul_pkg::dim_t      k,
    input  logic                  load_we,
    input  matmul_pkg::load_sel_t load_sel,
    input  matmul_pkg::addr_t     load_addr,
    input  matmul_pkg::word_t     load_data,
    input  matmul_pkg::addr_t     rd_addr,
    output matmul_pkg::word_t     rd_data,
    output logic                  busy,
    output logic                  done
);

    matmul_pkg::addr_t      in_addr;
    matmul_pkg::addr_t      wt_addr;
    matmul_pkg::word_t      in_data;
    matmul_pkg::word_t      wt_data;
    matmul_pkg::mac_tag_t   tag;
    matmul_pkg::result_wr_t result;

    logic in_we;
    logic wt_we;

    // host loads locked out while a run is in flight
    assign in_we = load_we && !busy && (load_sel == matmul_pkg::LOAD_INPUT);
    assign wt_we = load_we && !busy && (load_sel == matmul_pkg::LOAD_WEIGHT);

    matmul_sequencer seq0 (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .m       (m),
        .n       (n),
        .k       (k),
        .in_addr (in_addr),
        .wt_addr (wt_addr),
        .tag     (tag),
        .busy    (busy),
        .done    (done)
    );

    matrix_ram input_ram (
        .clk     (clk),
        .we      (in_we),
        .wr_addr (load_addr),
        .wr_data (load_data),
        .rd_addr (in_addr),
        .rd_data (in_data)
    );

    matrix_ram weight_ram (
        .clk     (clk),
        .we      (wt_we),
        .wr_addr (load_addr),
        .wr_data (load_data),
        .rd_addr (wt_addr),
        .rd_data (wt_data)
    );

    dot_product_mac mac0 (
        .clk    (clk),
        .reset  (reset),
        .tag    (tag),
        .a      (in_data),
        .b      (wt_data),
        .result (result)
    );

    // read side belongs to the host, mac only writes
    matrix_ram result_ram (
        .clk     (clk),
        .we      (result.we),
        .wr_addr (result.addr),
        .wr_data (result.data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

/* logic/matmul_sequencer.sv */
`timescale 1ns/1ps

module matmul_sequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  matmul_pkg::dim_t     m,
    input  matmul_pkg::dim_t     n,
    input  matmul_pkg::dim_t     k,
    output matmul_pkg::addr_t    in_addr,
    output matmul_pkg::addr_t    wt_addr,
    output matmul_pkg::mac_tag_t tag,
    output logic                 busy,
    output logic                 done
);

    matmul_pkg::seq_state_t state;
    matmul_pkg::seq_state_t next_state;

    matmul_pkg::dim_t  m_q;
    matmul_pkg::dim_t  n_q;
    matmul_pkg::dim_t  k_q;
    matmul_pkg::dim_t  i;
    matmul_pkg::dim_t  j;
    matmul_pkg::dim_t  p;
    matmul_pkg::addr_t out_addr;

    logic       start_ok;
    logic       issuing;     // high while terms are still being issued
    logic [1:0] drain_cnt;
    logic       last_p;
    logic       last_j;
    logic       last_i;
    logic       final_term;

    logic              tag_valid;
    logic              tag_first;
    logic              tag_last;
    matmul_pkg::addr_t tag_addr;

    assign start_ok = start && (m != '0) && (n != '0) && (k != '0);

    assign last_p     = (p == k_q - 1'b1);
    assign last_j     = (j == n_q - 1'b1);
    assign last_i     = (i == m_q - 1'b1);
    assign final_term = issuing && last_p && last_j && last_i;

    // row-major operand and result addresses
    assign in_addr  = matmul_pkg::addr_t'(i) * matmul_pkg::addr_t'(k_q) + matmul_pkg::addr_t'(p);
    assign wt_addr  = matmul_pkg::addr_t'(p) * matmul_pkg::addr_t'(n_q) + matmul_pkg::addr_t'(j);
    assign out_addr = matmul_pkg::addr_t'(i) * matmul_pkg::addr_t'(n_q) + matmul_pkg::addr_t'(j);

    always_comb begin
        next_state = state;
        case (state)
            matmul_pkg::IDLE: begin
                if (start_ok) next_state = matmul_pkg::COMPUTE;
            end
            matmul_pkg::COMPUTE: begin
                // last tag has cleared the ram and mac stages
                if (!issuing && drain_cnt == 2'd1) next_state = matmul_pkg::FINISH;
            end
            matmul_pkg::FINISH: next_state = matmul_pkg::IDLE;
            default: next_state = matmul_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= matmul_pkg::IDLE;
            issuing   <= 1'b0;
            drain_cnt <= 2'd0;
            done      <= 1'b0;
        end else begin
            state <= next_state;
            done  <= (state == matmul_pkg::FINISH);
            if (state == matmul_pkg::IDLE && start_ok) begin
                issuing <= 1'b1;
            end else if (final_term) begin
                issuing   <= 1'b0;
                drain_cnt <= 2'd2;
            end else if (state == matmul_pkg::COMPUTE && !issuing) begin
                drain_cnt <= drain_cnt - 2'd1;
            end
        end
    end

    // p fastest, then j, then i
    always_ff @(posedge clk) begin
        if (state == matmul_pkg::IDLE && start_ok) begin
            m_q <= m;
            n_q <= n;
            k_q <= k;
            i   <= '0;
            j   <= '0;
            p   <= '0;
        end else if (issuing) begin
            if (last_p) begin
                p <= '0;
                if (last_j) begin
                    j <= '0;
                    i <= i + 1'b1;
                end else begin
                    j <= j + 1'b1;
                end
            end else begin
                p <= p + 1'b1;
            end
        end
    end

    // tag delayed one cycle to meet the ram read data
    always_ff @(posedge clk) begin
        if (reset) begin
            tag_valid <= 1'b0;
        end else begin
            tag_valid <= issuing;
        end
    end

    always_ff @(posedge clk) begin
        tag_first <= (p == '0);
        tag_last  <= last_p;
        tag_addr  <= out_addr;
    end

    assign tag = '{valid: tag_valid, first: tag_first, last: tag_last, out_addr: tag_addr};

    assign busy = (state != matmul_pkg::IDLE) || done;

endmodule

/* logic/dot_product_mac.sv */
`timescale 1ns/1ps

module dot_product_mac (
    input  logic                   clk,
    input  logic                   reset,
    input  matmul_pkg::mac_tag_t   tag,
    input  matmul_pkg::word_t      a,
    input  matmul_pkg::word_t      b,
    output matmul_pkg::result_wr_t result
);

    matmul_pkg::word_t prod;
    matmul_pkg::word_t sum_next;
    matmul_pkg::word_t acc;
    matmul_pkg::addr_t res_addr;
    matmul_pkg::word_t res_data;
    logic              res_we;

    // 32x32 product kept to the low word
    assign prod     = matmul_pkg::word_t'(a * b);
    assign sum_next = tag.first ? prod : acc + prod;

    always_ff @(posedge clk) begin
        if (reset) begin
            res_we <= 1'b0;
        end else begin
            res_we <= tag.valid && tag.last;
        end
    end

    always_ff @(posedge clk) begin
        if (tag.valid) begin
            acc <= sum_next;
            if (tag.last) begin
                res_addr <= tag.out_addr;
                res_data <= sum_next;   // completed dot product
            end
        end
    end

    assign result = '{we: res_we, addr: res_addr, data: res_data};

endmodule

/* logic/matrix_ram.sv */
`timescale 1ns/1ps

module matrix_ram (
    input  logic              clk,
    input  logic              we,
    input  matmul_pkg::addr_t wr_addr,
    input  matmul_pkg::word_t wr_data,
    input  matmul_pkg::addr_t rd_addr,
    output matmul_pkg::word_t rd_data
);

    matmul_pkg::word_t mem [matmul_pkg::MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* logic/matmul_pkg.sv */
package matmul_pkg;

    localparam int WORD_W    = 32;
    localparam int ADDR_W    = 10;
    localparam int DIM_W     = 5;
    localparam int MEM_DEPTH = 1024;   // words per memory, all three the same

    // one matrix element or running sum, wraps on overflow
    typedef logic signed [WORD_W-1:0] word_t;

    typedef logic [ADDR_W-1:0] addr_t;

    // dimension or loop index, legal dimensions 1..31
    typedef logic [DIM_W-1:0] dim_t;

    typedef enum logic [1:0] {
        IDLE,
        COMPUTE,
        FINISH
    } seq_state_t;

    // which operand store a host load goes to
    typedef enum logic {
        LOAD_INPUT,
        LOAD_WEIGHT
    } load_sel_t;

    // rides alongside each operand read
    typedef struct packed {
        logic  valid;
        logic  first;      // first term of a dot product
        logic  last;       // last term, triggers the result write
        addr_t out_addr;   // i*n+j
    } mac_tag_t;

    typedef struct packed {
        logic  we;
        addr_t addr;
        word_t data;
    } result_wr_t;

endpackage
